//--- Bender.yml
package:
  name: nx_node

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/nx_pkg.sv
      - verilog/nx_route_stage.sv
      - verilog/nx_msg_decoder.sv
      - verilog/nx_logic_core.sv
      - verilog/nx_egress_stage.sv
      - verilog/nx_node.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/nx_node_tb.sv

//--- testbench/nx_node_tb.sv
// ---------------------------------------------------------------------------
// Node at row 2, column 2; every entry waits until the node is idle again
// Outbound ready is random only during the bypass burst
// ---------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "nx_defines.svh"

module nx_node_tb;

localparam int TIMEOUT  = 200;
localparam int BURST    = 8;
localparam int N_STIM   = 9;
// Wait conditions
localparam int W_BUSY   = 0;
localparam int W_IDLE   = 1;
localparam int W_OUT    = 2;

typedef struct packed {
    logic            send;
    nx_pkg::nx_msg_t msg;
    logic            trig;
    logic            exp_out;
    nx_pkg::nx_dir_t exp_dir;
    logic [31:0]     exp_data;
} entry_t;

// One outbound transfer as seen on the ports
typedef struct packed {
    nx_pkg::nx_dir_t dir;
    nx_pkg::nx_msg_t msg;
} seen_t;

logic                     clk_i;
logic                     reset_i;
logic [`NX_ROW_WIDTH-1:0] node_row_i;
logic [`NX_COL_WIDTH-1:0] node_col_i;
logic                     trigger_i;
logic                     idle_o;
nx_pkg::nx_msg_t          ib_msg_i;
logic                     ib_valid_i;
logic                     ib_ready_o;
nx_pkg::nx_msg_t          ob_north_data_o;
logic                     ob_north_valid_o;
logic                     ob_north_ready_i;
nx_pkg::nx_msg_t          ob_east_data_o;
logic                     ob_east_valid_o;
logic                     ob_east_ready_i;
nx_pkg::nx_msg_t          ob_south_data_o;
logic                     ob_south_valid_o;
logic                     ob_south_ready_i;
nx_pkg::nx_msg_t          ob_west_data_o;
logic                     ob_west_valid_o;
logic                     ob_west_ready_i;

entry_t      stim [N_STIM];
seen_t       seen_q [$];
int          checks = 0;
int          errors = 0;
bit          timed_out = 1'b0;
bit          bp_phase = 1'b0;
integer      seed = 38;
logic [31:0] rnd;

nx_node nx_node_inst (
      .clk_i(clk_i), .reset_i(reset_i)
    , .node_row_i(node_row_i), .node_col_i(node_col_i)
    , .trigger_i(trigger_i), .idle_o(idle_o)
    , .ib_msg_i(ib_msg_i), .ib_valid_i(ib_valid_i), .ib_ready_o(ib_ready_o)
    , .ob_north_data_o(ob_north_data_o), .ob_north_valid_o(ob_north_valid_o)
    , .ob_north_ready_i(ob_north_ready_i)
    , .ob_east_data_o(ob_east_data_o), .ob_east_valid_o(ob_east_valid_o)
    , .ob_east_ready_i(ob_east_ready_i)
    , .ob_south_data_o(ob_south_data_o), .ob_south_valid_o(ob_south_valid_o)
    , .ob_south_ready_i(ob_south_ready_i)
    , .ob_west_data_o(ob_west_data_o), .ob_west_valid_o(ob_west_valid_o)
    , .ob_west_ready_i(ob_west_ready_i)
);

initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
end

// Ready is random during the burst and all high otherwise
always @(posedge clk_i) begin
    #1;
    rnd = bp_phase ? $random(seed) : 32'hF;
    ob_north_ready_i = rnd[0];
    ob_east_ready_i  = rnd[1];
    ob_south_ready_i = rnd[2];
    ob_west_ready_i  = rnd[3];
end

// ---------------------------------------------------------------------------
// Outbound monitor sampling mid-cycle ahead of the transfer edge
// ---------------------------------------------------------------------------
always @(negedge clk_i) begin
    if (!reset_i) begin
        if (ob_north_valid_o && ob_north_ready_i)
            seen_q.push_back({nx_pkg::dir_north, ob_north_data_o});
        if (ob_east_valid_o && ob_east_ready_i)
            seen_q.push_back({nx_pkg::dir_east, ob_east_data_o});
        if (ob_south_valid_o && ob_south_ready_i)
            seen_q.push_back({nx_pkg::dir_south, ob_south_data_o});
        if (ob_west_valid_o && ob_west_ready_i)
            seen_q.push_back({nx_pkg::dir_west, ob_west_data_o});
    end
end

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("Error: %0d ns %s actual %h expected %h", $time, name, actual, expected);
    end
endtask

function automatic logic cond_met(input int what);
    case (what)
        W_BUSY:  return !idle_o;
        W_IDLE:  return idle_o;
        default: return ob_north_valid_o || ob_east_valid_o || ob_south_valid_o ||
                        ob_west_valid_o;
    endcase
endfunction

// Polls at the falling edge until the condition holds
task automatic wait_until(input int what, input string label);
    int n;
    n = 0;
    while (!cond_met(what) && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
    end
    if (!cond_met(what)) begin
        timed_out = 1'b1;
        $display("Timeout after %0d cycles waiting for %s", TIMEOUT, label);
    end
endtask

// Holds valid until ready is seen and returns just after the transfer edge
task automatic send_msg(input nx_pkg::nx_msg_t msg);
    int n;
    n = 0;
    ib_msg_i   = msg;
    ib_valid_i = 1'b1;
    @(negedge clk_i);
    while (!ib_ready_o && n < TIMEOUT) begin
        @(negedge clk_i);
        n++;
    end
    if (!ib_ready_o) begin
        timed_out = 1'b1;
        $display("Timeout after %0d cycles waiting for inbound ready", TIMEOUT);
    end
    @(posedge clk_i);
    #1;
    ib_valid_i = 1'b0;
endtask

function automatic entry_t make_entry(input logic send, input logic [31:0] msg,
                                      input logic trig, input logic exp_out,
                                      input nx_pkg::nx_dir_t dir, input logic [31:0] data);
    entry_t e;
    e.send     = send;
    e.msg      = msg;
    e.trig     = trig;
    e.exp_out  = exp_out;
    e.exp_dir  = dir;
    e.exp_data = data;
    return e;
endfunction

// Burst targets cycle through the four directions
function automatic logic [31:0] burst_msg(input int i);
    logic [7:0] tgt;
    case (i % 4)
        0:       tgt = 8'h27;
        1:       tgt = 8'h20;
        2:       tgt = 8'h92;
        default: tgt = 8'h02;
    endcase
    return {tgt, 16'hB000, 8'(i)};
endfunction

function automatic nx_pkg::nx_dir_t burst_dir(input int i);
    case (i % 4)
        0:       return nx_pkg::dir_east;
        1:       return nx_pkg::dir_west;
        2:       return nx_pkg::dir_south;
        default: return nx_pkg::dir_north;
    endcase
endfunction

// ---------------------------------------------------------------------------
// Main sequence
// ---------------------------------------------------------------------------
initial begin
    int     err_before;
    entry_t e;
    reset_i          = 1'b1;
    node_row_i       = 4'd2;
    node_col_i       = 4'd2;
    trigger_i        = 1'b0;
    ib_msg_i         = '0;
    ib_valid_i       = 1'b0;
    ob_north_ready_i = 1'b1;
    ob_east_ready_i  = 1'b1;
    ob_south_ready_i = 1'b1;
    ob_west_ready_i  = 1'b1;

    // Bypass routing goes by columns first then rows
    stim[0] = make_entry(1, 32'h32ABCDEF, 0, 1, nx_pkg::dir_south, 32'h32ABCDEF);
    stim[1] = make_entry(1, 32'h12135791, 0, 1, nx_pkg::dir_north, 32'h12135791);
    stim[2] = make_entry(1, 32'h2302468A, 0, 1, nx_pkg::dir_east,  32'h2302468A);
    stim[3] = make_entry(1, 32'h21FEDCBA, 0, 1, nx_pkg::dir_west,  32'h21FEDCBA);
    // XOR of inputs 0 and 1 into register 0
    stim[4] = make_entry(1, 32'h22001448, 0, 0, nx_pkg::dir_north, 32'h0);
    // Output 0 to row 0, column 2, input 5
    stim[5] = make_entry(1, 32'h22802810, 0, 0, nx_pkg::dir_north, 32'h0);
    // Input 0 set to 1
    stim[6] = make_entry(1, 32'h22400008, 0, 0, nx_pkg::dir_north, 32'h0);
    // Output 0 rises and a set-input with state 1 heads north
    stim[7] = make_entry(0, 32'h0, 1, 1, nx_pkg::dir_north, 32'h0240000D);
    // Nothing changed since the last send
    stim[8] = make_entry(0, 32'h0, 1, 0, nx_pkg::dir_north, 32'h0);

    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_value("ob_north_valid_o", ob_north_valid_o, 0);
    check_value("ob_east_valid_o", ob_east_valid_o, 0);
    check_value("ob_south_valid_o", ob_south_valid_o, 0);
    check_value("ob_west_valid_o", ob_west_valid_o, 0);
    check_value("idle_o", idle_o, 0);
    wait_until(W_IDLE, "idle after reset");

    for (int i = 0; i < N_STIM && !timed_out; i++) begin
        e = stim[i];
        err_before = errors;
        @(posedge clk_i);
        #1;
        if (e.send)
            send_msg(e.msg);
        if (e.trig) begin
            trigger_i = 1'b1;
            @(posedge clk_i);
            #1;
            trigger_i = 1'b0;
        end
        wait_until(W_BUSY, "node to leave idle");
        if (e.exp_out && !timed_out)
            wait_until(W_OUT, "outbound valid");
        if (!timed_out)
            wait_until(W_IDLE, "node to return to idle");
        check_value("outbound count", seen_q.size(), e.exp_out);
        if (e.exp_out && seen_q.size() > 0) begin
            check_value("outbound dir", seen_q[0].dir, e.exp_dir);
            check_value("outbound data", seen_q[0].msg, e.exp_data);
        end
        seen_q.delete();
        $display("Entry %0d finished with %0d errors", i, errors - err_before);
    end

    // Back-pressure burst sent back to back on the inbound side
    if (!timed_out) begin
        err_before = errors;
        bp_phase = 1'b1;
        @(posedge clk_i);
        #1;
        for (int i = 0; i < BURST && !timed_out; i++)
            send_msg(burst_msg(i));
        if (!timed_out)
            wait_until(W_IDLE, "burst to drain");
        bp_phase = 1'b0;
        check_value("burst count", seen_q.size(), BURST);
        for (int i = 0; i < BURST && i < seen_q.size(); i++) begin
            check_value("burst dir", seen_q[i].dir, burst_dir(i));
            check_value("burst data", seen_q[i].msg, burst_msg(i));
        end
        $display("Burst finished with %0d errors", errors - err_before);
    end

    $display("Checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out)
        $display("Test completed successfully");
    else
        $display("Test failed");
    $finish;
end

endmodule : nx_node_tb

`default_nettype wire

//--- verilog/nx_defines.svh
// ---------------------------------------------------------------------------
// Widths and depths shared by every stage of the node
// Outputs are taken from the lowest working registers
// ---------------------------------------------------------------------------
`ifndef NX_DEFINES_SVH
`define NX_DEFINES_SVH

// Node address
`define NX_ROW_WIDTH    4
`define NX_COL_WIDTH    4

// Message stream
`define NX_STREAM_WIDTH 32

// Simulated logic
`define NX_INPUTS       8
`define NX_OUTPUTS      8
`define NX_REGISTERS    8
`define NX_MAX_INSTRS   16

`endif

//--- verilog/nx_egress_stage.sv
// ---------------------------------------------------------------------------
// Output mapping, change detection and the outbound register
// Bypass always wins; mappings back to this node are not supported
// ---------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "nx_defines.svh"

module nx_egress_stage (
      input  wire logic                            clk_i
    , input  wire logic                            reset_i
    // Mapping updates
    , input  wire logic [$clog2(`NX_OUTPUTS)-1:0]  map_idx_i
    , input  wire logic [`NX_ROW_WIDTH-1:0]        map_row_i
    , input  wire logic [`NX_COL_WIDTH-1:0]        map_col_i
    , input  wire logic [$clog2(`NX_INPUTS)-1:0]   map_tgt_idx_i
    , input  wire logic                            map_valid_i
    // Core results
    , input  wire logic [`NX_OUTPUTS-1:0]          outputs_i
    , input  wire logic                            done_i
    // Bypass traffic
    , input  wire nx_pkg::nx_bypass_t              byp_i
    , input  wire logic                            byp_valid_i
    , output logic                                 byp_ready_o
    , input  wire logic [`NX_ROW_WIDTH-1:0]        node_row_i
    , input  wire logic [`NX_COL_WIDTH-1:0]        node_col_i
    // Outbound streams
    , output nx_pkg::nx_msg_t ob_north_data_o
    , output logic            ob_north_valid_o
    , input  wire logic       ob_north_ready_i
    , output nx_pkg::nx_msg_t ob_east_data_o
    , output logic            ob_east_valid_o
    , input  wire logic       ob_east_ready_i
    , output nx_pkg::nx_msg_t ob_south_data_o
    , output logic            ob_south_valid_o
    , input  wire logic       ob_south_ready_i
    , output nx_pkg::nx_msg_t ob_west_data_o
    , output logic            ob_west_valid_o
    , input  wire logic       ob_west_ready_i
    , output logic            idle_o
);

localparam int unsigned OUT_W = $clog2(`NX_OUTPUTS);

// Mapping table and last value sent per output
logic [`NX_OUTPUTS-1:0]         map_vld_q;
logic [`NX_OUTPUTS-1:0]         last_q;
logic [`NX_ROW_WIDTH-1:0]       map_row_q [`NX_OUTPUTS];
logic [`NX_COL_WIDTH-1:0]       map_col_q [`NX_OUTPUTS];
logic [$clog2(`NX_INPUTS)-1:0]  map_tidx_q [`NX_OUTPUTS];

logic               scan_q;
logic [OUT_W-1:0]   scan_idx_q;
logic               emit_req;
logic               emit_ack;
nx_pkg::nx_bypass_t emit;
nx_pkg::nx_bypass_t out_q;
logic               out_valid_q;
logic               out_ready;
logic               load_en;

// ---------------------------------------------------------------------------
// Scan for changed outputs
// ---------------------------------------------------------------------------

assign emit_req = scan_q && map_vld_q[scan_idx_q] &&
                  (outputs_i[scan_idx_q] != last_q[scan_idx_q]);

// Set-input message for the scanned output
always_comb begin
    emit.msg.tgt_row = map_row_q[scan_idx_q];
    emit.msg.tgt_col = map_col_q[scan_idx_q];
    emit.msg.command = nx_pkg::cmd_set_input;
    emit.msg.payload = '0;
    emit.msg.payload[2:0] = map_tidx_q[scan_idx_q];
    emit.msg.payload[3]   = outputs_i[scan_idx_q];
    emit.dir = nx_pkg::nx_route_dir(node_row_i, node_col_i, map_row_q[scan_idx_q],
                                    map_col_q[scan_idx_q]);
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        map_vld_q  <= '0;
        last_q     <= '0;
        scan_q     <= 1'b0;
        scan_idx_q <= '0;
    end else begin
        if (map_valid_i) begin
            map_vld_q[map_idx_i] <= 1'b1;
        end
        if (emit_ack) begin
            last_q[scan_idx_q] <= outputs_i[scan_idx_q];
        end
        // Restart on done, otherwise step past sent or unchanged outputs
        if (done_i) begin
            scan_q     <= 1'b1;
            scan_idx_q <= '0;
        end else if (scan_q && (!emit_req || emit_ack)) begin
            scan_idx_q <= scan_idx_q + 1'b1;
            if (scan_idx_q == OUT_W'(`NX_OUTPUTS - 1)) begin
                scan_q <= 1'b0;
            end
        end
    end
end

// Mapping targets
always_ff @(posedge clk_i) begin
    if (map_valid_i) begin
        map_row_q[map_idx_i]  <= map_row_i;
        map_col_q[map_idx_i]  <= map_col_i;
        map_tidx_q[map_idx_i] <= map_tgt_idx_i;
    end
end

// ---------------------------------------------------------------------------
// Merge and outbound register
// ---------------------------------------------------------------------------

always_comb begin
    case (out_q.dir)
        nx_pkg::dir_north: out_ready = ob_north_ready_i;
        nx_pkg::dir_east:  out_ready = ob_east_ready_i;
        nx_pkg::dir_south: out_ready = ob_south_ready_i;
        default:           out_ready = ob_west_ready_i;
    endcase
end

assign load_en     = !out_valid_q || out_ready;
assign byp_ready_o = load_en;
assign emit_ack    = load_en && !byp_valid_i && emit_req;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        out_valid_q <= 1'b0;
    end else if (load_en) begin
        out_valid_q <= byp_valid_i || emit_req;
    end
end

always_ff @(posedge clk_i) begin
    if (load_en) begin
        out_q <= byp_valid_i ? byp_i : emit;
    end
end

// Data fans out, valid only to its direction
assign ob_north_data_o  = out_q.msg;
assign ob_east_data_o   = out_q.msg;
assign ob_south_data_o  = out_q.msg;
assign ob_west_data_o   = out_q.msg;
assign ob_north_valid_o = out_valid_q && (out_q.dir == nx_pkg::dir_north);
assign ob_east_valid_o  = out_valid_q && (out_q.dir == nx_pkg::dir_east);
assign ob_south_valid_o = out_valid_q && (out_q.dir == nx_pkg::dir_south);
assign ob_west_valid_o  = out_valid_q && (out_q.dir == nx_pkg::dir_west);

assign idle_o = !scan_q && !out_valid_q;

endmodule : nx_egress_stage

`default_nettype wire

//--- verilog/nx_logic_core.sv
// ---------------------------------------------------------------------------
// Program store and sequencer; trigger is ignored while a run is going
// Loads past the store depth are dropped
// ---------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "nx_defines.svh"

module nx_logic_core (
      input  wire logic                           clk_i
    , input  wire logic                           reset_i
    , input  wire logic                           trigger_i
    // Instruction load
    , input  wire nx_pkg::nx_instr_t              instr_i
    , input  wire logic                           instr_valid_i
    // Input set
    , input  wire logic [$clog2(`NX_INPUTS)-1:0]  input_idx_i
    , input  wire logic                           input_state_i
    , input  wire logic                           input_valid_i
    // Results
    , output logic [`NX_OUTPUTS-1:0]              outputs_o
    , output logic                                done_o
    , output logic                                idle_o
);

// Count reaches the full depth, so one extra bit
localparam int unsigned PC_W = $clog2(`NX_MAX_INSTRS) + 1;

typedef enum logic {
    st_idle,
    st_run
} state_t;

nx_pkg::nx_instr_t        store_q [`NX_MAX_INSTRS];
logic [PC_W-1:0]          count_q;
logic [PC_W-1:0]          pc_q;
logic [`NX_INPUTS-1:0]    inputs_q;
logic [`NX_REGISTERS-1:0] regs_q;
state_t                   state_q;

nx_pkg::nx_instr_t cur;
logic              store_full;
logic              run_last;
logic              op_a;
logic              op_b;
logic              result;

assign store_full = (count_q == PC_W'(`NX_MAX_INSTRS));
assign run_last   = (pc_q == count_q);
assign cur        = store_q[pc_q[PC_W-2:0]];

// ---------------------------------------------------------------------------
// Execute
// ---------------------------------------------------------------------------

always_comb begin
    // Top source bit selects the input bits
    op_a = cur.src_a[3] ? inputs_q[cur.src_a[2:0]] : regs_q[cur.src_a[2:0]];
    op_b = cur.src_b[3] ? inputs_q[cur.src_b[2:0]] : regs_q[cur.src_b[2:0]];
    case (cur.opcode)
        nx_pkg::op_and:  result = op_a & op_b;
        nx_pkg::op_or:   result = op_a | op_b;
        nx_pkg::op_xor:  result = op_a ^ op_b;
        nx_pkg::op_nand: result = ~(op_a & op_b);
        nx_pkg::op_nor:  result = ~(op_a | op_b);
        nx_pkg::op_xnor: result = ~(op_a ^ op_b);
        nx_pkg::op_inv:  result = ~op_a;
        default:         result = op_a;
    endcase
end

// Program memory
always_ff @(posedge clk_i) begin
    if (instr_valid_i && !store_full) begin
        store_q[count_q[PC_W-2:0]] <= instr_i;
    end
end

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        count_q  <= '0;
        pc_q     <= '0;
        inputs_q <= '0;
        regs_q   <= '0;
        state_q  <= st_idle;
    end else begin
        if (instr_valid_i && !store_full) begin
            count_q <= count_q + 1'b1;
        end
        if (input_valid_i) begin
            inputs_q[input_idx_i] <= input_state_i;
        end
        case (state_q)
            st_idle: begin
                if (trigger_i) begin
                    state_q <= st_run;
                    pc_q    <= '0;
                end
            end
            default: begin
                // One instruction per cycle, last cycle only ends the run
                if (run_last) begin
                    state_q <= st_idle;
                end else begin
                    regs_q[cur.dst] <= result;
                    pc_q            <= pc_q + 1'b1;
                end
            end
        endcase
    end
end

assign outputs_o = regs_q[`NX_OUTPUTS-1:0];
assign done_o    = (state_q == st_run) && run_last;
assign idle_o    = (state_q == st_idle);

endmodule : nx_logic_core

`default_nettype wire

//--- verilog/nx_msg_decoder.sv
// ---------------------------------------------------------------------------
// Local message decoder, always ready; reserved commands are dropped
// ---------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "nx_defines.svh"

module nx_msg_decoder (
      input  wire logic                             clk_i
    , input  wire logic                             reset_i
    // Local messages
    , input  wire nx_pkg::nx_msg_t                  loc_msg_i
    , input  wire logic                             loc_valid_i
    , output logic                                  loc_ready_o
    // Instruction load
    , output nx_pkg::nx_instr_t                     instr_o
    , output logic                                  instr_valid_o
    // Input set
    , output logic [$clog2(`NX_INPUTS)-1:0]         input_idx_o
    , output logic                                  input_state_o
    , output logic                                  input_valid_o
    // Output mapping
    , output logic [$clog2(`NX_OUTPUTS)-1:0]        map_idx_o
    , output logic [`NX_ROW_WIDTH-1:0]              map_row_o
    , output logic [`NX_COL_WIDTH-1:0]              map_col_o
    , output logic [$clog2(`NX_INPUTS)-1:0]         map_tgt_idx_o
    , output logic                                  map_valid_o
    , output logic                                  idle_o
);

logic is_load;
logic is_set;
logic is_map;

assign loc_ready_o = 1'b1;

// Command decode
always_comb begin
    is_load = 1'b0;
    is_set  = 1'b0;
    is_map  = 1'b0;
    case (loc_msg_i.command)
        nx_pkg::cmd_load_instr: is_load = loc_valid_i;
        nx_pkg::cmd_set_input:  is_set  = loc_valid_i;
        nx_pkg::cmd_map_output: is_map  = loc_valid_i;
        default: ;
    endcase
end

// Strobes, one cycle each
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        instr_valid_o <= 1'b0;
        input_valid_o <= 1'b0;
        map_valid_o   <= 1'b0;
    end else begin
        instr_valid_o <= is_load;
        input_valid_o <= is_set;
        map_valid_o   <= is_map;
    end
end

// ---------------------------------------------------------------------------
// Payload unpacking
// ---------------------------------------------------------------------------

always_ff @(posedge clk_i) begin
    if (loc_valid_i) begin
        instr_o       <= nx_pkg::nx_instr_t'(loc_msg_i.payload[$bits(nx_pkg::nx_instr_t)-1:0]);
        // Set input: index low, state above
        input_idx_o   <= loc_msg_i.payload[2:0];
        input_state_o <= loc_msg_i.payload[3];
        // Map: index, column, row, then target input
        map_idx_o     <= loc_msg_i.payload[2:0];
        map_col_o     <= loc_msg_i.payload[6:3];
        map_row_o     <= loc_msg_i.payload[10:7];
        map_tgt_idx_o <= loc_msg_i.payload[13:11];
    end
end

// Nothing left to hand on
assign idle_o = !(instr_valid_o || input_valid_o || map_valid_o);

endmodule : nx_msg_decoder

`default_nettype wire

//--- verilog/nx_node.sv
// ---------------------------------------------------------------------------
// One logic node with a single inbound stream and four outbound streams
// ---------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "nx_defines.svh"

module nx_node (
      input  wire logic                     clk_i
    , input  wire logic                     reset_i
    , input  wire logic [`NX_ROW_WIDTH-1:0] node_row_i
    , input  wire logic [`NX_COL_WIDTH-1:0] node_col_i
    , input  wire logic                     trigger_i
    , output logic                          idle_o
    // Inbound stream
    , input  wire nx_pkg::nx_msg_t ib_msg_i
    , input  wire logic            ib_valid_i
    , output logic                 ib_ready_o
    // Outbound streams
    , output nx_pkg::nx_msg_t ob_north_data_o
    , output logic            ob_north_valid_o
    , input  wire logic       ob_north_ready_i
    , output nx_pkg::nx_msg_t ob_east_data_o
    , output logic            ob_east_valid_o
    , input  wire logic       ob_east_ready_i
    , output nx_pkg::nx_msg_t ob_south_data_o
    , output logic            ob_south_valid_o
    , input  wire logic       ob_south_ready_i
    , output nx_pkg::nx_msg_t ob_west_data_o
    , output logic            ob_west_valid_o
    , input  wire logic       ob_west_ready_i
);

nx_pkg::nx_msg_t    loc_msg;
logic               loc_valid;
logic               loc_ready;
nx_pkg::nx_bypass_t byp;
logic               byp_valid;
logic               byp_ready;

nx_pkg::nx_instr_t             instr;
logic                          instr_valid;
logic [$clog2(`NX_INPUTS)-1:0] input_idx;
logic                          input_state;
logic                          input_valid;

logic [$clog2(`NX_OUTPUTS)-1:0] map_idx;
logic [`NX_ROW_WIDTH-1:0]       map_row;
logic [`NX_COL_WIDTH-1:0]       map_col;
logic [$clog2(`NX_INPUTS)-1:0]  map_tgt_idx;
logic                           map_valid;

logic [`NX_OUTPUTS-1:0] core_outputs;
logic                   core_done;
logic                   decode_idle;
logic                   core_idle;
logic                   egress_idle;

// ---------------------------------------------------------------------------
// Pipeline stages
// ---------------------------------------------------------------------------

nx_route_stage route (
      .clk_i(clk_i), .reset_i(reset_i)
    , .node_row_i(node_row_i), .node_col_i(node_col_i)
    , .ib_msg_i(ib_msg_i), .ib_valid_i(ib_valid_i), .ib_ready_o(ib_ready_o)
    , .loc_msg_o(loc_msg), .loc_valid_o(loc_valid), .loc_ready_i(loc_ready)
    , .byp_o(byp), .byp_valid_o(byp_valid), .byp_ready_i(byp_ready)
);

nx_msg_decoder decoder (
      .clk_i(clk_i), .reset_i(reset_i)
    , .loc_msg_i(loc_msg), .loc_valid_i(loc_valid), .loc_ready_o(loc_ready)
    , .instr_o(instr), .instr_valid_o(instr_valid)
    , .input_idx_o(input_idx), .input_state_o(input_state), .input_valid_o(input_valid)
    , .map_idx_o(map_idx), .map_row_o(map_row), .map_col_o(map_col)
    , .map_tgt_idx_o(map_tgt_idx), .map_valid_o(map_valid)
    , .idle_o(decode_idle)
);

nx_logic_core core (
      .clk_i(clk_i), .reset_i(reset_i), .trigger_i(trigger_i)
    , .instr_i(instr), .instr_valid_i(instr_valid)
    , .input_idx_i(input_idx), .input_state_i(input_state), .input_valid_i(input_valid)
    , .outputs_o(core_outputs), .done_o(core_done), .idle_o(core_idle)
);

nx_egress_stage egress (
      .clk_i(clk_i), .reset_i(reset_i)
    , .map_idx_i(map_idx), .map_row_i(map_row), .map_col_i(map_col)
    , .map_tgt_idx_i(map_tgt_idx), .map_valid_i(map_valid)
    , .outputs_i(core_outputs), .done_i(core_done)
    , .byp_i(byp), .byp_valid_i(byp_valid), .byp_ready_o(byp_ready)
    , .node_row_i(node_row_i), .node_col_i(node_col_i)
    , .ob_north_data_o(ob_north_data_o), .ob_north_valid_o(ob_north_valid_o)
    , .ob_north_ready_i(ob_north_ready_i)
    , .ob_east_data_o(ob_east_data_o), .ob_east_valid_o(ob_east_valid_o)
    , .ob_east_ready_i(ob_east_ready_i)
    , .ob_south_data_o(ob_south_data_o), .ob_south_valid_o(ob_south_valid_o)
    , .ob_south_ready_i(ob_south_ready_i)
    , .ob_west_data_o(ob_west_data_o), .ob_west_valid_o(ob_west_valid_o)
    , .ob_west_ready_i(ob_west_ready_i)
    , .idle_o(egress_idle)
);

// Route stage is idle when its register is empty
always_ff @(posedge clk_i) begin
    if (reset_i) begin
        idle_o <= 1'b0;
    end else begin
        idle_o <= !loc_valid && !byp_valid && decode_idle && core_idle && egress_idle;
    end
end

endmodule : nx_node

`default_nettype wire

//--- verilog/nx_pkg.sv
// ---------------------------------------------------------------------------
// Message, instruction and routing types for the node
// Routing goes by columns first, then rows
// ---------------------------------------------------------------------------
`default_nettype none

`include "nx_defines.svh"

package nx_pkg;

    // Message command field
    typedef enum logic [1:0] {
        cmd_load_instr, cmd_set_input, cmd_map_output, cmd_reserved
    } nx_command_t;

    // Outbound direction
    typedef enum logic [1:0] {
        dir_north, dir_east, dir_south, dir_west
    } nx_dir_t;

    // Logic operations of the core
    typedef enum logic [2:0] {
        op_and, op_or, op_xor, op_nand, op_nor, op_xnor, op_inv, op_copy
    } nx_opcode_t;

    // Payload fills whatever the header leaves
    typedef struct packed {
        logic [`NX_ROW_WIDTH-1:0] tgt_row;
        logic [`NX_COL_WIDTH-1:0] tgt_col;
        nx_command_t              command;
        logic [`NX_STREAM_WIDTH-`NX_ROW_WIDTH-`NX_COL_WIDTH-3:0] payload;
    } nx_msg_t;

    // Source top bit picks an input bit over a register
    typedef struct packed {
        nx_opcode_t opcode;
        logic [3:0] src_a;
        logic [3:0] src_b;
        logic [2:0] dst;
    } nx_instr_t;

    typedef struct packed {
        nx_msg_t msg;
        nx_dir_t dir;
    } nx_bypass_t;

    function automatic nx_dir_t nx_route_dir(
        input logic [`NX_ROW_WIDTH-1:0] own_row,
        input logic [`NX_COL_WIDTH-1:0] own_col,
        input logic [`NX_ROW_WIDTH-1:0] tgt_row,
        input logic [`NX_COL_WIDTH-1:0] tgt_col
    );
        nx_dir_t dir;
        // Columns first
        if (tgt_col != own_col) begin
            dir = (tgt_col > own_col) ? dir_east : dir_west;
        end else begin
            dir = (tgt_row > own_row) ? dir_south : dir_north;
        end
        return dir;
    endfunction

endpackage : nx_pkg

`default_nettype wire

//--- verilog/nx_route_stage.sv
// ---------------------------------------------------------------------------
// Single-entry inbound register, split into local and bypass traffic
// ---------------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "nx_defines.svh"

module nx_route_stage (
      input  wire logic                     clk_i
    , input  wire logic                     reset_i
    // Own address
    , input  wire logic [`NX_ROW_WIDTH-1:0] node_row_i
    , input  wire logic [`NX_COL_WIDTH-1:0] node_col_i
    // Inbound stream
    , input  wire nx_pkg::nx_msg_t          ib_msg_i
    , input  wire logic                     ib_valid_i
    , output logic                          ib_ready_o
    // Messages for this node
    , output nx_pkg::nx_msg_t               loc_msg_o
    , output logic                          loc_valid_o
    , input  wire logic                     loc_ready_i
    // Messages passing through
    , output nx_pkg::nx_bypass_t            byp_o
    , output logic                          byp_valid_o
    , input  wire logic                     byp_ready_i
);

nx_pkg::nx_msg_t msg_q;
logic            full_q;
logic            is_local;
logic            drain;

// Address match on the held message
assign is_local = (msg_q.tgt_row == node_row_i) && (msg_q.tgt_col == node_col_i);

// Emptied this cycle by whichever side it goes to
assign drain = full_q && (is_local ? loc_ready_i : byp_ready_i);

// Accept when empty or emptying
assign ib_ready_o = !full_q || drain;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        full_q <= 1'b0;
    end else if (ib_valid_i && ib_ready_o) begin
        full_q <= 1'b1;
    end else if (drain) begin
        full_q <= 1'b0;
    end
end

// Held message
always_ff @(posedge clk_i) begin
    if (ib_valid_i && ib_ready_o) begin
        msg_q <= ib_msg_i;
    end
end

// ---------------------------------------------------------------------------
// Outputs
// ---------------------------------------------------------------------------

assign loc_msg_o   = msg_q;
assign loc_valid_o = full_q && is_local;

assign byp_o.msg   = msg_q;
assign byp_o.dir   = nx_pkg::nx_route_dir(node_row_i, node_col_i, msg_q.tgt_row,
                                          msg_q.tgt_col);
assign byp_valid_o = full_q && !is_local;

endmodule : nx_route_stage

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/nx_pkg.sv
verilog/nx_route_stage.sv
verilog/nx_msg_decoder.sv
verilog/nx_logic_core.sv
verilog/nx_egress_stage.sv
verilog/nx_node.sv
testbench/nx_node_tb.sv
